// ==== br_counter.sv ====
`timescale 1ns/10ps

module br_counter import br_pkg::*; (
	input logic clk,
	input logic reset,
	input logic iss_valid,
	input logic stall,
	input logic commit_valid,
	input logic res_valid,
	input logic flush,
	output logic iss_ready,
	output logic iss_fire,
	output br_cnt_t br_count,
	output br_cnt_t cmp_count,
	output br_idx_t res_idx
);

	br_cnt_t unresolved_pos;

	// a commit in this cycle frees a slot
	assign iss_ready = !stall && (br_count < br_cnt_t'(N_BR_ENTRY) || commit_valid);
	assign iss_fire = iss_valid && iss_ready;

	// oldest unresolved branch sits behind the resolved ones
	assign unresolved_pos = br_count - cmp_count;

	// index after the commit shift, which is where br_queue writes
	assign res_idx = br_idx_t'(unresolved_pos - br_cnt_t'(commit_valid));

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			br_count <= '0;
			cmp_count <= '0;
		end else begin
			br_count <= br_count + br_cnt_t'(iss_fire) - br_cnt_t'(commit_valid);
			cmp_count <= cmp_count + br_cnt_t'(iss_fire) - br_cnt_t'(res_valid);
		end
	end

endmodule

// ==== br_pkg.sv ====
package br_pkg;

	localparam int N_BR_ENTRY = 4;
	localparam int RAS_PTR_W = 3;
	localparam int DATA_W = 32;
	localparam int ADDR_W = 16;
	localparam int ROB_W = 5;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [ROB_W-1:0] rob_tag_t;
	typedef logic [RAS_PTR_W-1:0] ras_ptr_t;
	typedef logic [$clog2(N_BR_ENTRY)-1:0] br_idx_t;
	typedef logic [$clog2(N_BR_ENTRY):0] br_cnt_t;

	typedef enum logic {
		CMP_EQ,
		CMP_LE  // signed
	} cmp_op_t;

	typedef enum logic [1:0] {
		ST_RUN,
		ST_FLUSH,
		ST_REFILL
	} recover_state_t;

	typedef struct packed {
		logic valid;
		rob_tag_t tag;
		data_t data;
	} cdb_t;

	typedef struct packed {
		cmp_op_t op;
		cdb_t opd_a;
		cdb_t opd_b;
		logic prediction;  // 1 = taken
		addr_t addr_on_failure;
		rob_tag_t rob_tag;
	} br_issue_t;

	typedef struct packed {
		logic failure;
		logic prediction;
		addr_t addr_on_failure;
	} br_commit_t;

	// waiting compare
	typedef struct packed {
		cmp_op_t op;
		cdb_t opd_a;
		cdb_t opd_b;
	} cmp_entry_t;

	// in-order branch slot with its stack checkpoint
	typedef struct packed {
		logic prediction;
		addr_t addr_on_failure;
		rob_tag_t rob_tag;
		logic resolved;
		logic failure;
		ras_ptr_t ras_ptr;
		addr_t ras_addr;
	} br_entry_t;

endpackage

// ==== br_queue.sv ====
`timescale 1ns/10ps

module br_queue import br_pkg::*; (
	input logic clk,
	input logic reset,
	input logic iss_fire,
	input br_issue_t iss,
	input ras_ptr_t ras_top_ptr,
	input addr_t ras_top_addr,
	input logic res_valid,
	input logic res_taken,
	input br_idx_t res_idx,
	input rob_tag_t commit_tag,
	input br_cnt_t br_count,
	input logic flush,
	output logic commit_valid,
	output br_commit_t commit_info,
	output ras_ptr_t restore_ptr,
	output addr_t restore_addr,
	output logic speculating
);

	br_entry_t b [N_BR_ENTRY];
	br_entry_t nxt [N_BR_ENTRY];
	br_entry_t new_e;
	br_idx_t wr_idx;

	assign new_e.prediction = iss.prediction;
	assign new_e.addr_on_failure = iss.addr_on_failure;
	assign new_e.rob_tag = iss.rob_tag;
	assign new_e.resolved = 1'b0;
	assign new_e.failure = 1'b0;
	assign new_e.ras_ptr = ras_top_ptr;   // checkpoint at issue
	assign new_e.ras_addr = ras_top_addr;

	assign commit_valid = !flush && br_count != '0 && b[0].resolved
		&& b[0].rob_tag == commit_tag;

	assign commit_info.failure = b[0].failure;
	assign commit_info.prediction = b[0].prediction;
	assign commit_info.addr_on_failure = b[0].addr_on_failure;

	assign speculating = br_count != '0;

	// tail slot once the head has left
	assign wr_idx = br_idx_t'(br_count - br_cnt_t'(commit_valid));

	always_comb begin
		for (int i = 0; i < N_BR_ENTRY; i++)
			nxt[i] = b[i];
		if (commit_valid) begin
			for (int i = 0; i < N_BR_ENTRY - 1; i++)
				nxt[i] = b[i+1];
		end
		// res_idx already points into the shifted queue
		if (res_valid) begin
			nxt[res_idx].resolved = 1'b1;
			nxt[res_idx].failure = res_taken != nxt[res_idx].prediction;
		end
		if (iss_fire)
			nxt[wr_idx] = new_e;
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < N_BR_ENTRY; i++)
				b[i] <= nxt[i];
		end
	end

	// stack state of the committing branch, used in the flush cycle
	always_ff @(posedge clk) begin
		if (commit_valid) begin
			restore_ptr <= b[0].ras_ptr;
			restore_addr <= b[0].ras_addr;
		end
	end

endmodule

// ==== br_recover_fsm.sv ====
`timescale 1ns/10ps

module br_recover_fsm import br_pkg::*; (
	input logic clk,
	input logic reset,
	input logic commit_valid,
	input br_commit_t commit_info,
	output logic flush,
	output logic stall
);

	recover_state_t state;
	recover_state_t state_nxt;
	logic mispredict;

	assign mispredict = commit_valid && commit_info.failure;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_RUN: begin
				if (mispredict)
					state_nxt = ST_FLUSH;
			end
			ST_FLUSH: state_nxt = ST_REFILL;  // queues clear, stack restored
			ST_REFILL: state_nxt = ST_RUN;    // return_addr reloads
			default: state_nxt = ST_RUN;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= ST_RUN;
		else
			state <= state_nxt;
	end

	assign flush = state == ST_FLUSH;
	assign stall = state != ST_RUN;  // no issue during recovery

endmodule

// ==== br_unit.sv ====
`timescale 1ns/10ps

module br_unit import br_pkg::*; (
	input logic clk,
	input logic reset,
	input logic iss_valid,
	output logic iss_ready,
	input br_issue_t iss,
	input cdb_t cdb,
	input rob_tag_t commit_tag,
	output logic commit_valid,
	output br_commit_t commit_info,
	input logic ras_push,
	input logic ras_pop,
	input addr_t push_addr,
	output addr_t return_addr,
	output logic flush,
	output logic speculating
);

	logic iss_fire;
	logic stall;
	logic res_valid;
	logic res_taken;
	br_idx_t res_idx;
	br_cnt_t br_count;
	br_cnt_t cmp_count;
	ras_ptr_t ras_top_ptr;
	addr_t ras_top_addr;
	ras_ptr_t restore_ptr;
	addr_t restore_addr;

	br_counter i_counter (
		.clk(clk),
		.reset(reset),
		.iss_valid(iss_valid),
		.stall(stall),
		.commit_valid(commit_valid),
		.res_valid(res_valid),
		.flush(flush),
		.iss_ready(iss_ready),
		.iss_fire(iss_fire),
		.br_count(br_count),
		.cmp_count(cmp_count),
		.res_idx(res_idx)
	);

	cmp_queue i_cmp_queue (
		.clk(clk),
		.reset(reset),
		.iss_fire(iss_fire),
		.iss(iss),
		.cdb(cdb),
		.flush(flush),
		.cmp_count(cmp_count),
		.res_valid(res_valid),
		.res_taken(res_taken)
	);

	br_queue i_br_queue (
		.clk(clk),
		.reset(reset),
		.iss_fire(iss_fire),
		.iss(iss),
		.ras_top_ptr(ras_top_ptr),
		.ras_top_addr(ras_top_addr),
		.res_valid(res_valid),
		.res_taken(res_taken),
		.res_idx(res_idx),
		.commit_tag(commit_tag),
		.br_count(br_count),
		.flush(flush),
		.commit_valid(commit_valid),
		.commit_info(commit_info),
		.restore_ptr(restore_ptr),
		.restore_addr(restore_addr),
		.speculating(speculating)
	);

	ras i_ras (
		.clk(clk),
		.reset(reset),
		.push(ras_push),
		.pop(ras_pop),
		.push_addr(push_addr),
		.flush(flush),
		.restore_ptr(restore_ptr),
		.restore_addr(restore_addr),
		.top_ptr(ras_top_ptr),
		.top_addr(ras_top_addr),
		.return_addr(return_addr)
	);

	br_recover_fsm i_recover (
		.clk(clk),
		.reset(reset),
		.commit_valid(commit_valid),
		.commit_info(commit_info),
		.flush(flush),
		.stall(stall)
	);

endmodule

// ==== br_unit_sva.sv ====
`timescale 1ns/10ps

module br_unit_sva (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic iss_ready,
	input logic commit_valid
);

	int n_fail = 0;  // failed assertions, read at the end of the run

	// recovery pulse is a single cycle
	flush_one_cycle: assert property (@(posedge clk) disable iff (reset)
		flush |=> !flush)
		else begin
			$error("flush held for more than one cycle");
			n_fail++;
		end

	no_issue_in_flush: assert property (@(posedge clk) disable iff (reset)
		flush |-> !iss_ready)
		else begin
			$error("iss_ready high during flush");
			n_fail++;
		end

	no_commit_in_flush: assert property (@(posedge clk) disable iff (reset)
		flush |-> !commit_valid)
		else begin
			$error("commit_valid high during flush");
			n_fail++;
		end

endmodule

bind br_unit br_unit_sva i_sva (
	.clk(clk),
	.reset(reset),
	.flush(flush),
	.iss_ready(iss_ready),
	.commit_valid(commit_valid)
);

// ==== cmp_queue.sv ====
`timescale 1ns/10ps

module cmp_queue import br_pkg::*; (
	input logic clk,
	input logic reset,
	input logic iss_fire,
	input br_issue_t iss,
	input cdb_t cdb,
	input logic flush,
	input br_cnt_t cmp_count,
	output logic res_valid,
	output logic res_taken
);

	cmp_entry_t q [N_BR_ENTRY];
	cmp_entry_t upd [N_BR_ENTRY];  // after bus wakeup
	cmp_entry_t sh [N_BR_ENTRY];   // after head pop
	cmp_entry_t new_e;
	br_cnt_t live;
	logic head_ready;
	logic clear_q;

	// operand picks up the bus value when its tag is broadcast
	function automatic cdb_t wake(cdb_t opd, cdb_t bus);
		cdb_t r;
		r = opd;
		if (!opd.valid && bus.valid && bus.tag == opd.tag) begin
			r.valid = 1'b1;
			r.data = bus.data;
		end
		return r;
	endfunction

	assign new_e.op = iss.op;
	assign new_e.opd_a = wake(iss.opd_a, cdb);  // same-cycle broadcast counts
	assign new_e.opd_b = wake(iss.opd_b, cdb);

	always_comb begin
		for (int i = 0; i < N_BR_ENTRY; i++) begin
			upd[i].op = q[i].op;
			upd[i].opd_a = wake(q[i].opd_a, cdb);
			upd[i].opd_b = wake(q[i].opd_b, cdb);
		end
	end

	assign head_ready = cmp_count != '0 && q[0].opd_a.valid && q[0].opd_b.valid;
	assign res_valid = head_ready;

	always_comb begin
		case (q[0].op)
			CMP_EQ: res_taken = q[0].opd_a.data == q[0].opd_b.data;
			CMP_LE: res_taken = $signed(q[0].opd_a.data) <= $signed(q[0].opd_b.data);
			default: res_taken = 1'b0;
		endcase
	end

	always_comb begin
		for (int i = 0; i < N_BR_ENTRY; i++)
			sh[i] = upd[i];
		if (res_valid) begin
			for (int i = 0; i < N_BR_ENTRY - 1; i++)
				sh[i] = upd[i+1];
		end
	end

	assign live = cmp_count - br_cnt_t'(res_valid);

	// count is cleared in br_counter, entries past it are dead
	assign clear_q = reset || flush;

	always_ff @(posedge clk) begin
		if (!clear_q) begin
			for (int i = 0; i < N_BR_ENTRY; i++) begin
				if (i < int'(live))
					q[i] <= sh[i];
				else if (iss_fire && i == int'(live))
					q[i] <= new_e;  // tail write
			end
		end
	end

endmodule

// ==== ras.sv ====
`timescale 1ns/10ps

module ras import br_pkg::*; (
	input logic clk,
	input logic reset,
	input logic push,
	input logic pop,
	input addr_t push_addr,
	input logic flush,
	input ras_ptr_t restore_ptr,
	input addr_t restore_addr,
	output ras_ptr_t top_ptr,
	output addr_t top_addr,
	output addr_t return_addr
);

	localparam int N_SLOT = 2**RAS_PTR_W;

	addr_t mem [N_SLOT];
	ras_ptr_t ptr;
	ras_ptr_t ptr_nxt;
	addr_t top_nxt;
	logic wr_en;
	ras_ptr_t wr_ptr;
	addr_t wr_data;

	assign top_ptr = ptr;
	assign top_addr = mem[ptr];

	// flush wins, then push over pop
	always_comb begin
		if (flush)
			ptr_nxt = restore_ptr;
		else if (push)
			ptr_nxt = ptr + 1'b1;
		else if (pop)
			ptr_nxt = ptr - 1'b1;
		else
			ptr_nxt = ptr;
	end

	always_comb begin
		wr_en = flush || push;
		wr_ptr = ptr_nxt;
		wr_data = flush ? restore_addr : push_addr;  // restore repairs one slot
	end

	// written slot bypasses the array for the registered top
	assign top_nxt = wr_en ? wr_data : mem[ptr_nxt];

	always_ff @(posedge clk) begin
		if (reset)
			ptr <= '1;  // first push lands in slot 0
		else
			ptr <= ptr_nxt;
	end

	always_ff @(posedge clk) begin
		if (wr_en && !reset)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk) begin
		return_addr <= top_nxt;
	end

endmodule

// ==== tb_br_unit.sv ====
`timescale 1ns/10ps

module tb_br_unit import br_pkg::*; ();

	localparam int CLK_PERIOD = 10;
	localparam int N_TESTS = 6;
	localparam int TEST_CYCLES = 250;  // longest test is well below this
	localparam int MAX_WAIT = 20;
	localparam rob_tag_t IDLE_TAG = '1;  // never issued

	logic clk;
	logic reset;
	logic iss_valid;
	logic iss_ready;
	br_issue_t iss;
	cdb_t cdb;
	rob_tag_t commit_tag;
	logic commit_valid;
	br_commit_t commit_info;
	logic ras_push;
	logic ras_pop;
	addr_t push_addr;
	addr_t return_addr;
	logic flush;
	logic speculating;

	logic [31:0] lfsr;
	rob_tag_t next_tag;

	tb_clock i_clock (.clk(clk), .reset(reset));

	br_unit i_dut (.*);

	// galois lfsr, one step per bit
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
		end
		return r;
	endfunction

	function automatic logic taken_ref(input cmp_op_t op, input data_t a, input data_t b);
		if (op == CMP_EQ)
			return a == b;
		return $signed(a) <= $signed(b);
	endfunction

	function automatic cdb_t ready_opd(input data_t d);
		return {1'b1, rob_tag_t'(0), d};
	endfunction

	function automatic br_issue_t make_branch(input cmp_op_t op, input cdb_t a, input cdb_t b,
		input logic pred, input addr_t addr);
		br_issue_t r;
		r.op = op;
		r.opd_a = a;
		r.opd_b = b;
		r.prediction = pred;
		r.addr_on_failure = addr;
		r.rob_tag = next_tag;
		next_tag = next_tag + 1'b1;
		return r;
	endfunction

	task automatic stop_run(input string line);
		$display("%s", line);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic expect_val(input logic [31:0] got, input logic [31:0] want, input string what);
		assert (got === want)
		else stop_run($sformatf("error at %0d ns: %s is %0h, expected %0h",
			$time, what, got, want));
	endtask

	// called on a falling edge, returns on the one after the accepting edge
	task automatic issue_branch(input br_issue_t b);
		int waited;
		waited = 0;
		iss = b;
		iss_valid = 1'b1;
		#1;
		while (iss_ready !== 1'b1) begin
			@(negedge clk);
			#1;
			waited++;
			if (waited > MAX_WAIT)
				stop_run("issue handshake did not complete in time");
		end
		@(negedge clk);
		iss_valid = 1'b0;
	endtask

	task automatic wait_commit(output br_commit_t info);
		int waited;
		waited = 0;
		#1;
		while (commit_valid !== 1'b1) begin
			@(negedge clk);
			#1;
			waited++;
			if (waited > MAX_WAIT)
				stop_run("commit_valid never rose for the branch at commit_tag");
		end
		info = commit_info;
		@(negedge clk);  // head popped at this edge
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			#1;
			expect_val(commit_valid, 1'b0, "commit_valid");
			@(negedge clk);
		end
	endtask

	task automatic commit_and_check(input br_issue_t b, input logic fail_exp);
		br_commit_t info;
		commit_tag = b.rob_tag;
		wait_commit(info);
		commit_tag = IDLE_TAG;
		expect_val(info.failure, fail_exp, "commit_info.failure");
		expect_val(info.prediction, b.prediction, "commit_info.prediction");
		expect_val(info.addr_on_failure, b.addr_on_failure, "commit_info.addr_on_failure");
	endtask

	// entered on the falling edge inside FLUSH
	task automatic check_recovery(input rob_tag_t flushed_tag);
		commit_tag = flushed_tag;
		#1;
		expect_val(flush, 1'b1, "flush");
		expect_val(iss_ready, 1'b0, "iss_ready during flush");
		@(negedge clk);
		#1;
		expect_val(flush, 1'b0, "flush after one cycle");
		expect_val(iss_ready, 1'b0, "iss_ready during refill");
		expect_val(speculating, 1'b0, "speculating after flush");
		@(negedge clk);
		#1;
		expect_val(iss_ready, 1'b1, "iss_ready after refill");
		expect_val(commit_valid, 1'b0, "commit_valid of a flushed branch");
		@(negedge clk);
		commit_tag = IDLE_TAG;
	endtask

	task automatic push_ras(input addr_t a);
		ras_push = 1'b1;
		push_addr = a;
		@(negedge clk);
		ras_push = 1'b0;
		expect_val(return_addr, a, "return_addr after push");
	endtask

	task automatic pop_ras(input addr_t want);
		ras_pop = 1'b1;
		@(negedge clk);
		ras_pop = 1'b0;
		expect_val(return_addr, want, "return_addr after pop");
	endtask

	task automatic check_reset_state();
		#1;
		expect_val(iss_ready, 1'b1, "iss_ready");
		expect_val(speculating, 1'b0, "speculating");
		expect_val(commit_valid, 1'b0, "commit_valid");
		expect_val(flush, 1'b0, "flush");
		@(negedge clk);
	endtask

	task automatic ready_branches();
		br_issue_t b;
		cmp_op_t op;
		data_t a;
		data_t c;
		for (int i = 0; i < 8; i++) begin
			op = cmp_op_t'(1'(random_bits(1)));
			a = random_bits(32);
			c = random_bits(2) == 0 ? a : random_bits(32);  // equal now and then
			b = make_branch(op, ready_opd(a), ready_opd(c), 1'(random_bits(1)),
				addr_t'(random_bits(16)));
			issue_branch(b);
			idle_cycles(3);
			commit_and_check(b, taken_ref(op, a, c) != b.prediction);
		end
	endtask

	task automatic wakeup_branches();
		br_issue_t first;
		br_issue_t second;
		cdb_t pending;
		data_t v;
		v = random_bits(32) | 32'h1;  // differs from the stale zero
		pending = {1'b0, rob_tag_t'(30), data_t'(0)};
		first = make_branch(CMP_EQ, pending, ready_opd(v), 1'b1, 16'h1a00);
		second = make_branch(CMP_LE, ready_opd(v), ready_opd(v), 1'b1, 16'h1b00);
		issue_branch(first);
		issue_branch(second);
		commit_tag = second.rob_tag;
		idle_cycles(3);  // younger one waits for the head
		commit_tag = first.rob_tag;
		idle_cycles(3);
		cdb = {1'b1, rob_tag_t'(30), v};
		@(negedge clk);
		cdb = '0;
		commit_and_check(first, taken_ref(CMP_EQ, v, v) != 1'b1);
		commit_and_check(second, taken_ref(CMP_LE, v, v) != 1'b1);
	endtask

	task automatic back_pressure();
		br_issue_t b [5];
		data_t v;
		for (int i = 0; i < 5; i++) begin
			v = random_bits(32);
			b[i] = make_branch(CMP_EQ, ready_opd(v), ready_opd(v), 1'b1, addr_t'(16'h2000 + i));
		end
		for (int i = 0; i < 4; i++)
			issue_branch(b[i]);
		iss = b[4];
		iss_valid = 1'b1;
		#1;
		expect_val(iss_ready, 1'b0, "iss_ready with a full queue");
		@(negedge clk);
		commit_tag = b[0].rob_tag;
		#1;
		expect_val(commit_valid, 1'b1, "commit_valid");
		expect_val(iss_ready, 1'b1, "iss_ready while a commit frees a slot");
		@(negedge clk);
		iss_valid = 1'b0;
		commit_tag = IDLE_TAG;
		for (int i = 1; i < 5; i++)
			commit_and_check(b[i], 1'b0);
		expect_val(speculating, 1'b0, "speculating after drain");
	endtask

	task automatic mispredict_recovery();
		br_issue_t bad;
		br_issue_t young;
		data_t v;
		v = random_bits(32);
		bad = make_branch(CMP_EQ, ready_opd(v), ready_opd(v ^ 32'h1), 1'b1, 16'hbad0);
		young = make_branch(CMP_EQ, ready_opd(v), ready_opd(v), 1'b1, 16'h3000);
		issue_branch(bad);
		issue_branch(young);
		commit_and_check(bad, taken_ref(CMP_EQ, v, v ^ 32'h1) != 1'b1);
		check_recovery(young.rob_tag);
	endtask

	task automatic stack_restore();
		addr_t p [5];
		br_issue_t bad;
		data_t v;
		for (int i = 0; i < 5; i++)
			p[i] = addr_t'(random_bits(16));
		for (int i = 0; i < 3; i++)
			push_ras(p[i]);
		pop_ras(p[1]);
		pop_ras(p[0]);
		v = random_bits(32);
		bad = make_branch(CMP_LE, ready_opd(v), ready_opd(v), 1'b0, 16'h4000);
		issue_branch(bad);
		push_ras(p[3]);  // after the checkpoint
		push_ras(p[4]);
		commit_and_check(bad, taken_ref(CMP_LE, v, v) != 1'b0);
		check_recovery(IDLE_TAG);
		expect_val(return_addr, p[0], "return_addr after restore");
	endtask

	initial begin
		#(CLK_PERIOD * (10 + N_TESTS * TEST_CYCLES));
		$display("watchdog expired before the tests finished");
		$display(">>> FAIL");
		$fatal(1);
	end

	initial begin
		iss_valid = 1'b0;
		iss = '0;
		cdb = '0;
		commit_tag = IDLE_TAG;
		ras_push = 1'b0;
		ras_pop = 1'b0;
		push_addr = '0;
		lfsr = 32'h650ee9b6;
		next_tag = '0;
		@(negedge reset);
		check_reset_state();
		ready_branches();
		wakeup_branches();
		back_pressure();
		mispredict_recovery();
		stack_restore();
		if (i_dut.i_sva.n_fail == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			$display(">>> FAIL");
			$fatal(1);
		end
	end

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;  // 10 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// ==== vlog.f ====
br_pkg.sv
br_counter.sv
cmp_queue.sv
br_queue.sv
ras.sv
br_recover_fsm.sv
br_unit.sv
br_unit_sva.sv
tb_clock.sv
tb_br_unit.sv
